//--- design/cache_cfg_pkg.sv
//####################################################################
// Cache geometry package
// Default way, set and line sizes plus the address types used to
// split a load/store address into tag, index and word offset
//####################################################################

package cache_cfg_pkg;

    // Default geometry, overridden from the top level
    parameter int DEF_WAYS       = 2;
    parameter int DEF_SETS       = 8;
    parameter int DEF_LINE_WORDS = 4;

    // Byte address from the load/store unit
    typedef logic [31:0] addr_t;

    // Word address as seen on the memory bus
    typedef logic [29:0] word_addr_t;

endpackage

//--- design/mem_bus_pkg.sv
//####################################################################
// Memory bus package
// Word, byte-enable and burst types of the memory port, plus the
// state encoding of the cache controller
//####################################################################

package mem_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;

    // Burst length minus one, zero is a single word
    typedef logic [4:0]  rlen_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REQ_READ,
        FILLING,
        UNCACHED_WAIT,
        WRITE_WAIT
    } ctrl_state_t;

endpackage

//--- design/way_port_if.sv
//####################################################################
// Way port interface
// Shared read/write controls from the controller to every way, and
// the per-way hit results collected by the way selector
//####################################################################

interface way_port_if #(
    parameter int WAYS       = 2,
    parameter int SETS       = 8,
    parameter int LINE_WORDS = 4
);
    import mem_bus_pkg::*;

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 30 - OFF_W - IDX_W;

    // Read side, issued on request acceptance
    logic             rd_en;
    logic [IDX_W-1:0] rd_index;
    logic [OFF_W-1:0] rd_offset;
    logic [TAG_W-1:0] cmp_tag;

    // Write side
    logic             wr_data_en;
    logic [WAYS-1:0]  wr_way;
    logic [IDX_W-1:0] wr_index;
    logic [OFF_W-1:0] wr_offset;
    word_t            wr_data;
    be_t              wr_be;
    logic             tag_wr_en;
    logic             tag_valid;

    // Per-way results and their combined form
    logic             way_hit [WAYS];
    word_t            way_data [WAYS];
    logic             hit;
    logic [WAYS-1:0]  hit_way;
    word_t            hit_data;
    logic [WAYS-1:0]  repl_way;

    modport ctrl (
        output rd_en, rd_index, rd_offset, cmp_tag,
        output wr_data_en, wr_way, wr_index, wr_offset, wr_data, wr_be,
        output tag_wr_en, tag_valid,
        input  hit, hit_way, hit_data, repl_way
    );

    modport way (
        input  rd_en, rd_index, rd_offset, cmp_tag,
        input  wr_data_en, wr_way, wr_index, wr_offset, wr_data, wr_be,
        input  tag_wr_en, tag_valid,
        output way_hit, way_data
    );

    modport sel (
        input  way_hit, way_data,
        output hit, hit_way, hit_data, repl_way
    );

endinterface

//--- design/dcache_way.sv
//####################################################################
// Data cache way
// Valid and tag array plus a word-addressed data array with byte
// enables, read synchronously and compared against the lookup tag
//####################################################################

module dcache_way #(
    parameter int SETS       = 8,
    parameter int LINE_WORDS = 4,
    parameter int WAY_ID     = 0
) (
    input logic     clk,
    input logic     rst,
    way_port_if.way wp
);
    import mem_bus_pkg::*;

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 30 - OFF_W - IDX_W;

    logic [SETS-1:0]        valid_mem;
    logic [TAG_W-1:0]       tag_mem [SETS];
    word_t                  data_mem [SETS*LINE_WORDS];

    logic                   valid_q;
    logic [TAG_W-1:0]       tag_q;
    word_t                  data_q;

    logic                   sel;
    logic [IDX_W+OFF_W-1:0] wr_word;
    logic [IDX_W+OFF_W-1:0] rd_word;

    assign sel     = wp.wr_way[WAY_ID];
    assign wr_word = {wp.wr_index, wp.wr_offset};
    assign rd_word = {wp.rd_index, wp.rd_offset};

    // Tag update on a fill or a sweep of the valid bits
    always_ff @(posedge clk) begin
        if (wp.tag_wr_en && sel) begin
            valid_mem[wp.wr_index] <= wp.tag_valid;
            tag_mem[wp.wr_index]   <= wp.cmp_tag;
        end
    end

    // Byte-enabled word write
    always_ff @(posedge clk) begin
        if (wp.wr_data_en && sel) begin
            for (int b = 0; b < 4; b++) begin
                if (wp.wr_be[b])
                    data_mem[wr_word][8*b +: 8] <= wp.wr_data[8*b +: 8];
            end
        end
    end

    // Registered read, valid flag cleared so no stale hit after reset
    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else if (wp.rd_en)
            valid_q <= valid_mem[wp.rd_index];
    end

    always_ff @(posedge clk) begin
        if (wp.rd_en) begin
            tag_q  <= tag_mem[wp.rd_index];
            data_q <= data_mem[rd_word];
        end
    end

    // Compare against the tag of the request in lookup
    assign wp.way_hit[WAY_ID]  = valid_q & (tag_q == wp.cmp_tag);
    assign wp.way_data[WAY_ID] = data_q;

endmodule

//--- design/way_select.sv
//####################################################################
// Way selector
// Reduces the per-way hits to a hit flag and data word, and keeps
// the round-robin replacement pointer
//####################################################################

module way_select #(
    parameter int WAYS = 2
) (
    input logic     clk,
    input logic     rst,
    input logic     adv,
    way_port_if.sel wp
);
    import mem_bus_pkg::*;

    logic [WAYS-1:0] ptr;
    logic            any_hit;
    word_t           hit_word;

    // Hit vector and data mux, at most one way hits
    always_comb begin
        any_hit  = 1'b0;
        hit_word = '0;
        for (int i = 0; i < WAYS; i++) begin
            wp.hit_way[i] = wp.way_hit[i];
            any_hit       = any_hit | wp.way_hit[i];
            if (wp.way_hit[i])
                hit_word = hit_word | wp.way_data[i];
        end
    end

    assign wp.hit      = any_hit;
    assign wp.hit_data = hit_word;

    // One-hot pointer, rotates once per cacheable miss
    always_ff @(posedge clk) begin
        if (rst)
            ptr <= WAYS'(1);
        else if (adv)
            ptr <= (ptr << 1) | (ptr >> (WAYS - 1));
    end

    assign wp.repl_way = ptr;

endmodule

//--- design/dcache_ctrl.sv
//####################################################################
// Data cache controller
// Request stage, miss/write state machine, memory requests, load
// response and the valid-bit sweep after reset
//####################################################################

module dcache_ctrl #(
    parameter int WAYS       = 2,
    parameter int SETS       = 8,
    parameter int LINE_WORDS = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    // Load/store side
    input  logic                      ls_valid,
    output logic                      ls_ready,
    input  cache_cfg_pkg::addr_t      ls_addr,
    input  mem_bus_pkg::word_t        ls_wdata,
    input  mem_bus_pkg::be_t          ls_be,
    input  logic                      ls_rnw,
    input  logic                      ls_uncacheable,
    output logic                      rd_valid,
    output mem_bus_pkg::word_t        rd_data,
    // Memory side
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    output cache_cfg_pkg::word_addr_t mem_addr,
    output logic                      mem_rnw,
    output mem_bus_pkg::word_t        mem_wdata,
    output mem_bus_pkg::be_t          mem_wbe,
    output mem_bus_pkg::rlen_t        mem_rlen,
    input  logic                      mem_rvalid,
    input  mem_bus_pkg::word_t        mem_rdata,
    // Replacement advance and way port
    output logic                      adv,
    way_port_if.ctrl                  wp
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 30 - OFF_W - IDX_W;

    ctrl_state_t      state;
    ctrl_state_t      next_state;

    // Stage 1 request
    addr_t            s1_addr;
    word_t            s1_wdata;
    be_t              s1_be;
    logic             s1_rnw;
    logic             s1_unc;

    logic             accept;
    logic             in_lookup;
    logic             in_fill;
    logic             s1_cached_rd;
    logic             lookup_hit;
    logic             lookup_miss;
    logic             write_hit;
    logic             lookup_done;
    logic             last_beat;
    logic [WAYS-1:0]  fill_way;
    logic [OFF_W-1:0] beat_cnt;
    logic             sweep_busy;
    logic [IDX_W-1:0] sweep_idx;

    assign accept = ls_valid & ls_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_addr  <= ls_addr;
            s1_wdata <= ls_wdata;
            s1_be    <= ls_be;
            s1_rnw   <= ls_rnw;
            s1_unc   <= ls_uncacheable;
        end
    end

    assign in_lookup    = (state == LOOKUP);
    assign in_fill      = (state == FILLING);
    assign s1_cached_rd = s1_rnw & ~s1_unc;
    assign lookup_hit   = in_lookup & s1_cached_rd & wp.hit;
    assign lookup_miss  = in_lookup & s1_cached_rd & ~wp.hit;
    assign write_hit    = in_lookup & ~s1_rnw & ~s1_unc & wp.hit;
    assign lookup_done  = lookup_hit | (in_lookup & ~s1_rnw & mem_req_ready);
    assign last_beat    = mem_rvalid & (beat_cnt == OFF_W'(LINE_WORDS - 1));

    // Held low while a write hit updates a way, avoids read-after-write
    assign ls_ready = ~sweep_busy & ((state == IDLE) | (lookup_done & ~write_hit));

    // Valid-bit sweep, one set per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == IDX_W'(SETS - 1))
                sweep_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == REQ_READ)
                beat_cnt <= '0;
            else if (in_fill && mem_rvalid)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Way picked at the miss, the pointer moves on right after
    always_ff @(posedge clk) begin
        if (lookup_miss)
            fill_way <= wp.repl_way;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:
                if (accept)
                    next_state = LOOKUP;
            LOOKUP:
                if (lookup_done)
                    next_state = accept ? LOOKUP : IDLE;
                else if (s1_rnw)
                    next_state = REQ_READ;
                else
                    next_state = WRITE_WAIT;
            REQ_READ:
                if (mem_req_ready)
                    next_state = s1_unc ? UNCACHED_WAIT : FILLING;
            FILLING:
                if (last_beat)
                    next_state = IDLE;
            UNCACHED_WAIT:
                if (mem_rvalid)
                    next_state = IDLE;
            WRITE_WAIT:
                if (mem_req_ready)
                    next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    // Memory request, writes go out straight from lookup
    assign mem_req_valid = (state == REQ_READ) | (state == WRITE_WAIT) | (in_lookup & ~s1_rnw);
    assign mem_rnw       = s1_rnw;
    assign mem_addr      = s1_cached_rd ? {s1_addr[31:OFF_W+2], {OFF_W{1'b0}}} : s1_addr[31:2];
    assign mem_wdata     = s1_wdata;
    assign mem_wbe       = s1_be;
    assign mem_rlen      = s1_cached_rd ? rlen_t'(LINE_WORDS - 1) : '0;

    // Load response
    assign rd_valid = lookup_hit
                    | (in_fill & mem_rvalid & (beat_cnt == s1_addr[2 +: OFF_W]))
                    | ((state == UNCACHED_WAIT) & mem_rvalid);
    assign rd_data  = in_lookup ? wp.hit_data : mem_rdata;

    assign adv = lookup_miss;

    // Way reads follow the request being accepted
    assign wp.rd_en     = accept;
    assign wp.rd_index  = ls_addr[OFF_W+2 +: IDX_W];
    assign wp.rd_offset = ls_addr[2 +: OFF_W];
    assign wp.cmp_tag   = s1_addr[31 -: TAG_W];

    // Way writes from write hits, fill beats, tag installs and the sweep
    assign wp.wr_data_en = write_hit | (in_fill & mem_rvalid);
    assign wp.tag_wr_en  = lookup_miss | sweep_busy;
    assign wp.tag_valid  = ~sweep_busy;
    assign wp.wr_index   = sweep_busy ? sweep_idx : s1_addr[OFF_W+2 +: IDX_W];
    assign wp.wr_offset  = in_fill ? beat_cnt : s1_addr[2 +: OFF_W];
    assign wp.wr_data    = in_fill ? mem_rdata : s1_wdata;
    assign wp.wr_be      = in_fill ? 4'hf : s1_be;

    always_comb begin
        if (sweep_busy)
            wp.wr_way = '1;
        else if (in_fill)
            wp.wr_way = fill_way;
        else if (lookup_miss)
            wp.wr_way = wp.repl_way;
        else
            wp.wr_way = wp.hit_way;
    end

endmodule

//--- design/dcache_top.sv
//####################################################################
// L1 data cache top level
// Set-associative, write-through, no write allocate, round-robin
// replacement with whole-line fills on read misses
//####################################################################

module dcache_top #(
    parameter int WAYS       = cache_cfg_pkg::DEF_WAYS,
    parameter int SETS       = cache_cfg_pkg::DEF_SETS,
    parameter int LINE_WORDS = cache_cfg_pkg::DEF_LINE_WORDS
) (
    input  logic                      clk,
    input  logic                      rst,
    // Load/store request and response
    input  logic                      ls_valid,
    output logic                      ls_ready,
    input  cache_cfg_pkg::addr_t      ls_addr,
    input  mem_bus_pkg::word_t        ls_wdata,
    input  mem_bus_pkg::be_t          ls_be,
    input  logic                      ls_rnw,
    input  logic                      ls_uncacheable,
    output logic                      rd_valid,
    output mem_bus_pkg::word_t        rd_data,
    // Memory port
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    output cache_cfg_pkg::word_addr_t mem_addr,
    output logic                      mem_rnw,
    output mem_bus_pkg::word_t        mem_wdata,
    output mem_bus_pkg::be_t          mem_wbe,
    output mem_bus_pkg::rlen_t        mem_rlen,
    input  logic                      mem_rvalid,
    input  mem_bus_pkg::word_t        mem_rdata
);

    logic adv;

    way_port_if #(
        .WAYS       (WAYS),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) wp ();

    dcache_ctrl #(
        .WAYS       (WAYS),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) i_dcache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .ls_valid       (ls_valid),
        .ls_ready       (ls_ready),
        .ls_addr        (ls_addr),
        .ls_wdata       (ls_wdata),
        .ls_be          (ls_be),
        .ls_rnw         (ls_rnw),
        .ls_uncacheable (ls_uncacheable),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_addr       (mem_addr),
        .mem_rnw        (mem_rnw),
        .mem_wdata      (mem_wdata),
        .mem_wbe        (mem_wbe),
        .mem_rlen       (mem_rlen),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata),
        .adv            (adv),
        .wp             (wp.ctrl)
    );

    // One instance per way, each drives its own hit slice
    for (genvar i = 0; i < WAYS; i++) begin : g_way
        dcache_way #(
            .SETS       (SETS),
            .LINE_WORDS (LINE_WORDS),
            .WAY_ID     (i)
        ) i_dcache_way (
            .clk (clk),
            .rst (rst),
            .wp  (wp.way)
        );
    end

    way_select #(
        .WAYS (WAYS)
    ) i_way_select (
        .clk (clk),
        .rst (rst),
        .adv (adv),
        .wp  (wp.sel)
    );

endmodule

//--- tb/dcache_chk.sv
//####################################################################
// Data cache handshake checks
// Concurrent assertions on the load/store and memory handshakes,
// bound into the cache top level
//####################################################################

module dcache_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      ls_valid,
    input logic                      ls_ready,
    input cache_cfg_pkg::addr_t      ls_addr,
    input mem_bus_pkg::word_t        ls_wdata,
    input mem_bus_pkg::be_t          ls_be,
    input logic                      ls_rnw,
    input logic                      ls_uncacheable,
    input logic                      rd_valid,
    input logic                      mem_req_valid,
    input logic                      mem_req_ready,
    input cache_cfg_pkg::word_addr_t mem_addr,
    input logic                      mem_rnw,
    input mem_bus_pkg::word_t        mem_wdata,
    input mem_bus_pkg::be_t          mem_wbe,
    input mem_bus_pkg::rlen_t        mem_rlen,
    input logic                      mem_rvalid
);

    // Read beats promised by accepted reads and not yet returned
    logic [7:0] beats_owed;
    logic [7:0] beats_new;

    assign beats_new = (mem_req_valid && mem_req_ready && mem_rnw) ?
                       8'(mem_rlen) + 8'd1 : 8'd0;

    always_ff @(posedge clk) begin
        if (rst)
            beats_owed <= '0;
        else
            beats_owed <= beats_owed + beats_new - 8'(mem_rvalid);
    end

    ls_hold: assert property (@(posedge clk) disable iff (rst)
        ls_valid && !ls_ready |=> ls_valid && $stable(ls_addr) && $stable(ls_wdata)
            && $stable(ls_be) && $stable(ls_rnw) && $stable(ls_uncacheable))
        else $error("load/store request changed while stalled");

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr)
            && $stable(mem_rnw) && $stable(mem_wdata) && $stable(mem_wbe)
            && $stable(mem_rlen))
        else $error("memory request changed while stalled");

    beat_owed: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> beats_owed != 8'd0)
        else $error("read beat with no read outstanding");

    // Quiet outputs once reset has been seen for a full cycle
    reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !rd_valid && !mem_req_valid)
        else $error("output active during reset");

endmodule

bind dcache_top dcache_chk i_dcache_chk (.*);

//--- tb/dcache_tb.sv
//####################################################################
// Data cache testbench
// Runs a stimulus table against a randomly stalling memory model
// and checks loads, hit timing and bus requests against references
//####################################################################

module dcache_tb;
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int WAYS       = 2;
    localparam int SETS       = 8;
    localparam int LINE_WORDS = 4;
    localparam int OFF_W      = $clog2(LINE_WORDS);
    localparam int IDX_W      = $clog2(SETS);
    localparam int MEM_WORDS  = 1024;
    localparam int NUM_STIM   = 26;

    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    // Direct change of a backing word without bus traffic
    localparam logic [1:0] OP_POKE = 2'd2;

    typedef struct packed {
        logic [1:0] op;
        logic       unc;
        addr_t      addr;
        word_t      data;
        be_t        be;
    } stim_t;

    typedef struct packed {
        addr_t       addr;
        word_t       exp_data;
        logic        unc;
        logic        exp_hit;
        logic [31:0] acc_cycle;
        logic        burst_seen;
    } load_t;

    typedef struct packed {
        word_addr_t addr;
        word_t      data;
        be_t        be;
    } store_t;

    logic       clk;
    logic       rst;
    logic       ls_valid;
    logic       ls_ready;
    addr_t      ls_addr;
    word_t      ls_wdata;
    be_t        ls_be;
    logic       ls_rnw;
    logic       ls_uncacheable;
    logic       rd_valid;
    word_t      rd_data;
    logic       mem_req_valid;
    logic       mem_req_ready;
    word_addr_t mem_addr;
    logic       mem_rnw;
    word_t      mem_wdata;
    be_t        mem_wbe;
    rlen_t      mem_rlen;
    logic       mem_rvalid;
    word_t      mem_rdata;

    word_t       mem [MEM_WORDS];
    word_t       shadow [MEM_WORDS];
    stim_t       stim [NUM_STIM];
    load_t       load_q [$];
    store_t      store_q [$];
    word_addr_t  beat_q [$];
    logic [31:0] rng;
    int          cycle;
    int          check_count;
    int          error_count;
    // Read beats granted on the bus and not yet returned
    int          beats_left;

    // Round-robin reference of the resident lines
    logic        ref_valid [WAYS][SETS];
    logic [31:0] ref_tag [WAYS][SETS];
    int          ref_ptr;

    dcache_top #(
        .WAYS       (WAYS),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) i_dcache_top (
        .clk            (clk),
        .rst            (rst),
        .ls_valid       (ls_valid),
        .ls_ready       (ls_ready),
        .ls_addr        (ls_addr),
        .ls_wdata       (ls_wdata),
        .ls_be          (ls_be),
        .ls_rnw         (ls_rnw),
        .ls_uncacheable (ls_uncacheable),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_addr       (mem_addr),
        .mem_rnw        (mem_rnw),
        .mem_wdata      (mem_wdata),
        .mem_wbe        (mem_wbe),
        .mem_rlen       (mem_rlen),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Reports a hit for a resident line and otherwise installs it at the pointer
    function automatic logic ref_lookup(addr_t a);
        int          idx;
        logic [31:0] tag;
        idx = int'(a[2+OFF_W +: IDX_W]);
        tag = a >> (2 + OFF_W + IDX_W);
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag)
                return 1'b1;
        end
        ref_valid[ref_ptr][idx] = 1'b1;
        ref_tag[ref_ptr][idx]   = tag;
        ref_ptr = (ref_ptr + 1) % WAYS;
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_count++;
        if (exp_v !== act_v) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // One row per entry with operation, uncacheable flag, byte address,
    // write data and byte enables
    task automatic load_stim();
        stim = '{
            '{OP_RD,   1'b0, 32'h040, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h044, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h04c, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h048, 32'h0,         4'h0},
            '{OP_WR,   1'b0, 32'h044, 32'hdeadbeef,  4'h6},
            '{OP_RD,   1'b0, 32'h044, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h040, 32'h0,         4'h0},
            '{OP_WR,   1'b0, 32'h228, 32'h12345678,  4'h9},
            '{OP_RD,   1'b0, 32'h228, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h22c, 32'h0,         4'h0},
            '{OP_RD,   1'b1, 32'h300, 32'h0,         4'h0},
            '{OP_POKE, 1'b0, 32'h300, 32'ha5a50f0f,  4'hf},
            '{OP_RD,   1'b1, 32'h300, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h000, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h080, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h004, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h100, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h000, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h08c, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h10c, 32'h0,         4'h0},
            '{OP_RD,   1'b0, 32'h088, 32'h0,         4'h0},
            '{OP_WR,   1'b0, 32'h104, 32'hcafef00d,  4'hf},
            '{OP_RD,   1'b0, 32'h104, 32'h0,         4'h0},
            '{OP_RD,   1'b1, 32'h044, 32'h0,         4'h0},
            '{OP_WR,   1'b0, 32'hff8, 32'h0badc0de,  4'hc},
            '{OP_RD,   1'b0, 32'hff8, 32'h0,         4'h0}
        };
    endtask

    // Waits one edge first so the last acceptance is already queued
    task automatic wait_idle();
        @(posedge clk);
        while (load_q.size() != 0 || store_q.size() != 0 || beat_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic apply_entry(input stim_t e);
        if (e.op == OP_POKE) begin
            ls_valid <= 1'b0;
            wait_idle();
            mem[e.addr[11:2]]    = e.data;
            shadow[e.addr[11:2]] = e.data;
        end else begin
            ls_valid       <= 1'b1;
            ls_addr        <= e.addr;
            ls_wdata       <= e.data;
            ls_be          <= e.be;
            ls_rnw         <= (e.op == OP_RD);
            ls_uncacheable <= e.unc;
            @(posedge clk);
            while (!ls_ready)
                @(posedge clk);
        end
    endtask

    task automatic accept_request();
        load_t  ld;
        store_t st;
        int     wi;
        wi = int'(ls_addr[11:2]);
        if (ls_rnw) begin
            ld.addr       = ls_addr;
            ld.exp_data   = shadow[wi];
            ld.unc        = ls_uncacheable;
            ld.exp_hit    = 1'b0;
            ld.acc_cycle  = cycle;
            ld.burst_seen = 1'b0;
            if (!ls_uncacheable)
                ld.exp_hit = ref_lookup(ls_addr);
            load_q.push_back(ld);
        end else begin
            shadow[wi] = merge_bytes(shadow[wi], ls_wdata, ls_be);
            st.addr    = ls_addr[31:2];
            st.data    = ls_wdata;
            st.be      = ls_be;
            store_q.push_back(st);
        end
    endtask

    task automatic check_read_req();
        load_t ld;
        if (load_q.size() == 0) begin
            report_error("memory read issued with no load outstanding");
        end else begin
            ld = load_q[0];
            if (ld.exp_hit)
                report_error("memory read issued for a load expected to hit");
            if (ld.burst_seen)
                report_error("second memory read issued for one load");
            if (ld.unc) begin
                check_value("mem_rlen", 0, 32'(mem_rlen));
                check_value("mem_addr", ld.addr >> 2, 32'(mem_addr));
            end else begin
                check_value("mem_rlen", LINE_WORDS - 1, 32'(mem_rlen));
                check_value("mem_addr", (ld.addr >> (2 + OFF_W)) << OFF_W, 32'(mem_addr));
            end
            load_q[0].burst_seen = 1'b1;
        end
    endtask

    task automatic check_write_req();
        store_t st;
        if (store_q.size() == 0) begin
            report_error("memory write issued with no store outstanding");
        end else begin
            st = store_q.pop_front();
            check_value("mem_addr", 32'(st.addr), 32'(mem_addr));
            check_value("mem_wdata", st.data, mem_wdata);
            check_value("mem_wbe", 32'(st.be), 32'(mem_wbe));
        end
    endtask

    // Response and request monitor sampled on the rising edge
    always @(posedge clk) begin
        load_t ld;
        if (!rst) begin
            // Request stalls and fills keep the load/store side closed
            if (ls_ready && (beats_left != 0 || (mem_req_valid && !mem_req_ready)))
                report_error("ls_ready high while the cache waits on memory");
            if (rd_valid) begin
                if (load_q.size() == 0) begin
                    report_error("rd_valid asserted with no load outstanding");
                end else begin
                    ld = load_q.pop_front();
                    check_value("rd_data", ld.exp_data, rd_data);
                    if (ld.exp_hit)
                        check_value("hit_latency", 1, 32'(cycle) - ld.acc_cycle);
                    else if (!ld.burst_seen)
                        report_error("load expected to miss completed without a memory read");
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_rnw) begin
                    check_read_req();
                    beats_left = beats_left + int'(mem_rlen) + 1;
                end else begin
                    check_write_req();
                end
            end
            if (mem_rvalid)
                beats_left = beats_left - 1;
            if (ls_valid && ls_ready)
                accept_request();
        end
        cycle = cycle + 1;
    end

    // Memory model with random request stalls and beat gaps
    always @(posedge clk) begin
        logic [31:0] r;
        word_addr_t  wa;
        if (rst) begin
            mem_req_ready <= 1'b0;
            mem_rvalid    <= 1'b0;
        end else begin
            r = next_rand();
            mem_req_ready <= (r[1:0] != 2'b00);
            if (beat_q.size() != 0 && r[3:2] != 2'b00) begin
                wa = beat_q.pop_front();
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem[wa[9:0]];
            end else begin
                mem_rvalid <= 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_rnw) begin
                    for (int k = 0; k <= int'(mem_rlen); k++)
                        beat_q.push_back(mem_addr + word_addr_t'(k));
                end else begin
                    mem[mem_addr[9:0]] = merge_bytes(mem[mem_addr[9:0]], mem_wdata, mem_wbe);
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_STIM * 200) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", NUM_STIM * 200);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rng            = 32'ha649;
        cycle          = 0;
        check_count    = 0;
        error_count    = 0;
        beats_left     = 0;
        ref_ptr        = 0;
        rst            = 1'b1;
        ls_valid       = 1'b0;
        ls_addr        = '0;
        ls_wdata       = '0;
        ls_be          = '0;
        ls_rnw         = 1'b1;
        ls_uncacheable = 1'b0;
        mem_req_ready  = 1'b0;
        mem_rvalid     = 1'b0;
        mem_rdata      = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = next_rand();
            shadow[i] = mem[i];
        end
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        load_stim();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_STIM; i++)
            apply_entry(stim[i]);
        ls_valid <= 1'b0;
        wait_idle();
        repeat (4) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- all.f
design/cache_cfg_pkg.sv
design/mem_bus_pkg.sv
design/way_port_if.sv
design/dcache_way.sv
design/way_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/dcache_chk.sv
tb/dcache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -Mdir obj_dir -f all.f

out=$(./obj_dir/Vdcache_tb 2>&1) || true
printf '%s\n' "$out"

# Pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "All tests passed!"
